// File: Makefile
# Verilator build and run for the pcpu testbench

SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= pcpu_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 1
FILELIST  := src.f
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for failure"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP OBJ_DIR LOG SEED"

$(BIN): $(FILELIST) $(SOURCES) tests/pcpu_cases.txt
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	set -o pipefail; $(BIN) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: logic/pcpu.sv
`timescale 1ns/10ps

module pcpu #(
	parameter pcpu_pkg::word_t RESET_PC   = 32'h0000_0000,
	parameter pcpu_pkg::word_t EXC_VECTOR = 32'h0000_0080
) (
	input  logic            clk,
	input  logic            arst_n,
	input  pcpu_pkg::word_t inst_data,   // Same-cycle answer to inst_addr
	input  pcpu_pkg::word_t mem_data_in, // Load data, same cycle
	input  logic [5:0]      irq,
	output pcpu_pkg::word_t inst_addr,
	output pcpu_pkg::word_t mem_addr,
	output pcpu_pkg::word_t mem_data,
	output logic            mem_we
);
	import pcpu_pkg::*;

	word_t      pc_q;
	word_t      pc_d;
	logic       ex_valid;
	word_t      ex_pc;
	word_t      ex_inst;
	ctrl_t      ctrl;
	reg_addr_t  rs_addr;
	reg_addr_t  rt_addr;
	word_t      rs_data;
	word_t      rt_data;
	word_t      rs_val;
	word_t      rt_val;
	word_t      imm;
	word_t      alu_b;
	word_t      alu_result;
	logic       alu_ovf;
	word_t      cp0_rdata;
	logic       trap;
	logic       cp0_redirect;
	word_t      cp0_target;
	word_t      ex_pc4;
	word_t      br_target;
	word_t      jmp_target;
	logic       br_taken;
	logic       jmp_taken;
	logic       redirect;
	mem_stage_t mem_q;
	mem_stage_t mem_d;
	word_t      mem_fwd;

	////////////////////
	// Fetch
	////////////////////

	assign inst_addr = pc_q;

	// CP0 first, then beq, then j
	always_comb begin
		pc_d = pc_q + 32'd4;
		if (cp0_redirect) begin
			pc_d = cp0_target;
		end else if (br_taken) begin
			pc_d = br_target;
		end else if (jmp_taken) begin
			pc_d = jmp_target;
		end
	end

	assign redirect = cp0_redirect || br_taken || jmp_taken;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_q     <= RESET_PC;
			ex_valid <= 1'b0;
		end else begin
			pc_q     <= pc_d;
			ex_valid <= !redirect; // Squash the word fetched behind a redirect
		end
	end

	always_ff @(posedge clk) begin
		ex_pc   <= pc_q;
		ex_inst <= inst_data;
	end

	////////////////////
	// Execute
	////////////////////

	pcpu_decode u_decode (
		.inst (ex_inst),
		.ctrl (ctrl)
	);

	assign rs_addr = ex_inst[25:21];
	assign rt_addr = ex_inst[20:16];

	pcpu_regfile u_regfile (
		.clk     (clk),
		.arst_n  (arst_n),
		.rs_addr (rs_addr),
		.rt_addr (rt_addr),
		.we      (mem_q.reg_we),
		.wa      (mem_q.dest),
		.wd      (mem_fwd),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// Memory stage value, load data for lw
	assign mem_fwd = mem_q.mem_rd ? mem_data_in : mem_q.result;

	// One bypass level covers everything, regfile holds older writes
	always_comb begin
		rs_val = rs_data;
		rt_val = rt_data;
		if (mem_q.valid && mem_q.reg_we && mem_q.dest != '0) begin
			if (mem_q.dest == rs_addr) rs_val = mem_fwd;
			if (mem_q.dest == rt_addr) rt_val = mem_fwd;
		end
	end

	assign imm   = ctrl.sign_ext ? {{16{ex_inst[15]}}, ex_inst[15:0]} : {16'h0000, ex_inst[15:0]};
	assign alu_b = ctrl.use_imm ? imm : rt_val;

	pcpu_alu u_alu (
		.a        (rs_val),
		.b        (alu_b),
		.op       (ctrl.alu_op),
		.result   (alu_result),
		.overflow (alu_ovf)
	);

	pcpu_cp0 #(
		.EXC_VECTOR (EXC_VECTOR)
	) u_cp0 (
		.clk      (clk),
		.arst_n   (arst_n),
		.valid    (ex_valid),
		.ctrl     (ctrl),
		.overflow (alu_ovf),
		.pc       (ex_pc),
		.wdata    (rt_val),
		.irq      (irq),
		.rdata    (cp0_rdata),
		.trap     (trap),
		.redirect (cp0_redirect),
		.target   (cp0_target)
	);

	// No delay slot, targets relative to pc + 4
	assign ex_pc4     = ex_pc + 32'd4;
	assign br_target  = ex_pc4 + {imm[29:0], 2'b00};
	assign jmp_target = {ex_pc4[31:28], ex_inst[25:0], 2'b00};
	assign br_taken   = ex_valid && ctrl.branch && (rs_val == rt_val);
	assign jmp_taken  = ex_valid && ctrl.jump;

	////////////////////
	// Memory stage
	////////////////////

	// A trapping instruction leaves nothing behind
	always_comb begin
		mem_d.valid      = ex_valid && !trap;
		mem_d.reg_we     = mem_d.valid && ctrl.reg_we;
		mem_d.dest       = ctrl.dest;
		mem_d.mem_rd     = mem_d.valid && ctrl.mem_rd;
		mem_d.mem_wr     = mem_d.valid && ctrl.mem_wr;
		mem_d.result     = ctrl.mfc0 ? cp0_rdata : alu_result;
		mem_d.store_data = rt_val;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_q <= '0;
		end else begin
			mem_q <= mem_d;
		end
	end

	assign mem_addr = mem_q.result;
	assign mem_data = mem_q.store_data;
	assign mem_we   = mem_q.mem_wr; // Already qualified by valid

endmodule

// File: logic/pcpu_alu.sv
`timescale 1ns/10ps

module pcpu_alu (
	input  pcpu_pkg::word_t   a,
	input  pcpu_pkg::word_t   b,
	input  pcpu_pkg::alu_op_e op,
	output pcpu_pkg::word_t   result,
	output logic              overflow
);
	import pcpu_pkg::*;

	word_t sum;
	word_t diff;
	logic  add_ovf;
	logic  sub_ovf;

	assign sum  = a + b;
	assign diff = a - b;

	// Same operand signs, result sign flipped
	assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
	// Operand signs differ, result sign follows b
	assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

	always_comb begin
		case (op)
			ALU_ADD: result = sum;
			ALU_SUB: result = diff;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_SLT: result = {31'd0, $signed(a) < $signed(b)}; // Signed compare
			ALU_LUI: result = {b[15:0], 16'h0000};
			default: result = sum;
		endcase
	end

	// Flag only, CP0 decides if it traps
	always_comb begin
		case (op)
			ALU_ADD: overflow = add_ovf;
			ALU_SUB: overflow = sub_ovf;
			default: overflow = 1'b0;
		endcase
	end

endmodule

// File: logic/pcpu_cp0.sv
`timescale 1ns/10ps

module pcpu_cp0 #(
	parameter pcpu_pkg::word_t EXC_VECTOR = 32'h0000_0080
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            valid,     // Execute stage holds an instruction
	input  pcpu_pkg::ctrl_t ctrl,
	input  logic            overflow,
	input  pcpu_pkg::word_t pc,        // Execute PC
	input  pcpu_pkg::word_t wdata,     // rt operand for mtc0
	input  logic [5:0]      irq,
	output pcpu_pkg::word_t rdata,
	output logic            trap,
	output logic            redirect,
	output pcpu_pkg::word_t target
);
	import pcpu_pkg::*;

	// Status bit positions
	localparam int ST_IE  = 0;
	localparam int ST_EXL = 1;
	localparam word_t STATUS_WMASK = 32'h0000_fc03; // IM, EXL, IE writable

	word_t     status_q;
	word_t     epc_q;
	word_t     cause;
	exc_code_e exc_q;
	exc_code_e exc_d;
	logic [5:0] ip_q;
	logic      int_req;
	logic      ri_req;
	logic      sys_req;
	logic      ov_req;
	logic      eret_go;
	logic      mtc0_go;

	////////////////////
	// Exception sources
	////////////////////

	// IE set, not in handler, any unmasked line
	assign int_req = valid && status_q[ST_IE] && !status_q[ST_EXL] &&
		|(irq & status_q[15:10]);
	assign ri_req  = valid && ctrl.reserved;
	assign sys_req = valid && ctrl.syscall;
	assign ov_req  = valid && ctrl.trap_ovf && overflow;

	assign trap = int_req || ri_req || sys_req || ov_req;

	// Fixed priority, interrupt first
	always_comb begin
		if (int_req) begin
			exc_d = EXC_INT;
		end else if (ri_req) begin
			exc_d = EXC_RI;
		end else if (sys_req) begin
			exc_d = EXC_SYS;
		end else begin
			exc_d = EXC_OV;
		end
	end

	assign eret_go = valid && ctrl.eret && !trap;
	assign mtc0_go = valid && ctrl.mtc0 && !trap; // Killed by a trap like any write

	assign redirect = trap || eret_go;
	assign target   = trap ? EXC_VECTOR : epc_q;

	////////////////////
	// Registers
	////////////////////

	assign cause = {16'h0000, ip_q, 3'b000, exc_q, 2'b00}; // IP at 15:10, ExcCode at 6:2

	always_comb begin
		case (ctrl.cp0_sel)
			CP0_STATUS: rdata = status_q;
			CP0_CAUSE:  rdata = cause;
			CP0_EPC:    rdata = epc_q;
			default:    rdata = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status_q <= '0;
			exc_q    <= EXC_INT;
			ip_q     <= '0;
		end else begin
			ip_q <= irq; // Pending lines, sampled every cycle
			if (trap) begin
				status_q[ST_EXL] <= 1'b1;
				exc_q            <= exc_d;
			end else if (eret_go) begin
				status_q[ST_EXL] <= 1'b0;
			end else if (mtc0_go && ctrl.cp0_sel == CP0_STATUS) begin
				status_q <= wdata & STATUS_WMASK;
			end
		end
	end

	// Return address
	always_ff @(posedge clk) begin
		if (trap) begin
			epc_q <= pc;
		end else if (mtc0_go && ctrl.cp0_sel == CP0_EPC) begin
			epc_q <= wdata;
		end
	end

endmodule

// File: logic/pcpu_decode.sv
`timescale 1ns/10ps

module pcpu_decode (
	input  pcpu_pkg::word_t inst,
	output pcpu_pkg::ctrl_t ctrl
);
	import pcpu_pkg::*;

	// COP0 rs field sub-ops
	localparam logic [4:0] COP_MF = 5'b00000;
	localparam logic [4:0] COP_MT = 5'b00100;
	localparam logic [5:0] ERET_FUNCT = 6'h18;

	op_e       op;
	funct_e    funct;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	logic      cp0_reg_ok;

	assign op    = op_e'(inst[31:26]);
	assign funct = funct_e'(inst[5:0]);
	assign rs    = inst[25:21];
	assign rt    = inst[20:16];
	assign rd    = inst[15:11];

	// Only Status, Cause and EPC exist
	assign cp0_reg_ok = (rd == CP0_STATUS) || (rd == CP0_CAUSE) || (rd == CP0_EPC);

	always_comb begin
		ctrl         = '0;
		ctrl.alu_op  = ALU_ADD;
		ctrl.dest    = rt;                // I-type and mfc0 write rt
		ctrl.cp0_sel = cp0_reg_e'(rd);
		case (op)
			OP_RTYPE: begin
				ctrl.dest   = rd;
				ctrl.reg_we = 1'b1;
				case (funct)
					F_ADD: ctrl.trap_ovf = 1'b1;
					F_SUB: begin
						ctrl.alu_op   = ALU_SUB;
						ctrl.trap_ovf = 1'b1;
					end
					F_AND: ctrl.alu_op = ALU_AND;
					F_OR:  ctrl.alu_op = ALU_OR;
					F_SLT: ctrl.alu_op = ALU_SLT;
					F_SYSCALL: begin
						ctrl.reg_we  = 1'b0;
						ctrl.syscall = 1'b1;
					end
					default: begin
						ctrl.reg_we   = 1'b0;
						ctrl.reserved = 1'b1; // Unknown funct
					end
				endcase
			end
			OP_ADDI: begin
				ctrl.use_imm  = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.trap_ovf = 1'b1;
				ctrl.reg_we   = 1'b1;
			end
			OP_ANDI: begin
				ctrl.alu_op  = ALU_AND;
				ctrl.use_imm = 1'b1;       // Zero extended
				ctrl.reg_we  = 1'b1;
			end
			OP_ORI: begin
				ctrl.alu_op  = ALU_OR;
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			OP_LUI: begin
				ctrl.alu_op  = ALU_LUI;
				ctrl.use_imm = 1'b1;
				ctrl.reg_we  = 1'b1;
			end
			OP_LW: begin
				ctrl.use_imm  = 1'b1;      // Address = rs + offset
				ctrl.sign_ext = 1'b1;
				ctrl.mem_rd   = 1'b1;
				ctrl.reg_we   = 1'b1;
			end
			OP_SW: begin
				ctrl.use_imm  = 1'b1;
				ctrl.sign_ext = 1'b1;
				ctrl.mem_wr   = 1'b1;
			end
			OP_BEQ: begin
				ctrl.branch   = 1'b1;
				ctrl.sign_ext = 1'b1;      // Word offset
			end
			OP_J: ctrl.jump = 1'b1;
			OP_COP0: begin
				if (inst[25] && inst[24:6] == '0 && inst[5:0] == ERET_FUNCT) begin
					ctrl.eret = 1'b1;
				end else if (rs == COP_MF && inst[10:0] == '0 && cp0_reg_ok) begin
					ctrl.mfc0   = 1'b1;
					ctrl.reg_we = 1'b1;
				end else if (rs == COP_MT && inst[10:0] == '0 && cp0_reg_ok) begin
					ctrl.mtc0 = 1'b1;
				end else begin
					ctrl.reserved = 1'b1; // Bad form or missing register
				end
			end
			default: ctrl.reserved = 1'b1;
		endcase
	end

endmodule

// File: logic/pcpu_pkg.sv
package pcpu_pkg;

	////////////////////
	// Basic types
	////////////////////

	typedef logic [31:0] word_t;     // Data and address word
	typedef logic [4:0]  reg_addr_t; // GPR index

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_ADDI  = 6'h08,
		OP_ANDI  = 6'h0c,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_COP0  = 6'h10,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} op_e;

	// R-type funct field, inst[5:0]
	typedef enum logic [5:0] {
		F_SYSCALL = 6'h0c,
		F_ADD     = 6'h20,
		F_SUB     = 6'h22,
		F_AND     = 6'h24,
		F_OR      = 6'h25,
		F_SLT     = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT,
		ALU_LUI // Immediate into upper half
	} alu_op_e;

	// Cause.ExcCode values
	typedef enum logic [4:0] {
		EXC_INT = 5'd0,
		EXC_SYS = 5'd8,
		EXC_RI  = 5'd10,
		EXC_OV  = 5'd12
	} exc_code_e;

	// Implemented CP0 registers, rd field of mfc0/mtc0
	typedef enum logic [4:0] {
		CP0_STATUS = 5'd12,
		CP0_CAUSE  = 5'd13,
		CP0_EPC    = 5'd14
	} cp0_reg_e;

	////////////////////
	// Pipeline structs
	////////////////////

	typedef struct packed {
		alu_op_e   alu_op;
		logic      use_imm;  // Immediate as ALU operand b
		logic      sign_ext; // Else zero extend
		logic      trap_ovf; // add, sub, addi
		logic      reg_we;
		reg_addr_t dest;
		logic      mem_rd;
		logic      mem_wr;
		logic      branch;   // beq
		logic      jump;     // j
		logic      mfc0;
		logic      mtc0;
		logic      eret;
		logic      syscall;
		logic      reserved; // Unknown encoding
		cp0_reg_e  cp0_sel;
	} ctrl_t;

	typedef struct packed {
		logic      valid;
		logic      reg_we;
		reg_addr_t dest;
		logic      mem_rd;
		logic      mem_wr;
		word_t     result;     // ALU or CP0 value, also load/store address
		word_t     store_data;
	} mem_stage_t;

endpackage

// File: logic/pcpu_regfile.sv
`timescale 1ns/10ps

module pcpu_regfile (
	input  logic               clk,
	input  logic               arst_n,
	input  pcpu_pkg::reg_addr_t rs_addr,
	input  pcpu_pkg::reg_addr_t rt_addr,
	input  logic               we,
	input  pcpu_pkg::reg_addr_t wa,
	input  pcpu_pkg::word_t     wd,
	output pcpu_pkg::word_t     rs_data,
	output pcpu_pkg::word_t     rt_data
);
	import pcpu_pkg::*;

	word_t regs [32];

	// Write at end of memory stage
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we && wa != '0) begin // $0 never written
			regs[wa] <= wd;
		end
	end

	// Two async read ports
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: src.f
logic/pcpu_pkg.sv
logic/pcpu_alu.sv
logic/pcpu_regfile.sv
logic/pcpu_decode.sv
logic/pcpu_cp0.sv
logic/pcpu.sv
tests/pcpu_tb.sv

// File: tests/pcpu_cases.txt
# Columns: kind addr data. P program word, D data word, Q irq value at fetch addr,
# S expected store addr and data in bus order, F fetch addr that must be reached
P 00000000 3c018000 # lui  $1, 0x8000
P 00000004 34021234 # ori  $2, $0, 0x1234
P 00000008 2043fffc # addi $3, $2, -4
P 0000000c 00622022 # sub  $4, $3, $2
P 00000010 0082282a # slt  $5, $4, $2
P 00000014 00813024 # and  $6, $4, $1
P 00000018 00c53825 # or   $7, $6, $5
P 0000001c 30e8ff01 # andi $8, $7, 0xff01
P 00000020 ac070100 # sw   $7, 0x100($0)
P 00000024 ac080104 # sw   $8, 0x104($0)
P 00000028 ac040108 # sw   $4, 0x108($0)
P 0000002c 8c090300 # lw   $9, 0x300($0)
P 00000030 212a0008 # addi $10, $9, 8
P 00000034 ac0a010c # sw   $10, 0x10c($0)
P 00000038 11050001 # beq  $8, $5, taken
P 0000003c ac0001f0 # sw   never
P 00000040 11000001 # beq  $8, $0, not taken
P 00000044 ac020110 # sw   $2, 0x110($0)
P 00000048 08000014 # j    0x50
P 0000004c ac0001f4 # sw   never
P 00000050 341c0200 # ori  $28, $0, 0x200
P 00000054 00211020 # add  $2, $1, $1 overflows
P 00000058 ac020114 # sw   $2, 0x114($0)
P 0000005c fc000000 # reserved
P 00000060 0000000c # syscall
P 00000064 340c0c01 # ori  $12, $0, 0x0c01
P 00000068 408c6000 # mtc0 $12, Status
P 0000006c 340d1001 # ori  $13, $0, 0x1001
P 00000070 ac0d0118 # sw   $13, 0x118($0)
P 00000074 08000030 # j    0xc0
P 00000080 401a6800 # mfc0 $26, Cause
P 00000084 401b7000 # mfc0 $27, EPC
P 00000088 335a007c # andi $26, $26, 0x7c
P 0000008c af9a0000 # sw   $26, 0($28)
P 00000090 af9b0004 # sw   $27, 4($28)
P 00000094 239c0008 # addi $28, $28, 8
P 00000098 13400001 # beq  $26, $0, skip
P 0000009c 237b0004 # addi $27, $27, 4
P 000000a0 409b7000 # mtc0 $27, EPC
P 000000a4 42000018 # eret
P 000000c0 340e0055 # ori  $14, $0, 0x55
P 000000c4 ac0e011c # sw   $14, 0x11c($0)
P 000000c8 408d6000 # mtc0 $13, Status
P 000000cc 340f0077 # ori  $15, $0, 0x77
P 000000d0 ac0f0120 # sw   $15, 0x120($0)
P 000000d4 08000035 # j    0xd4
D 00000300 12345678
Q 00000070 04       # masked line
Q 000000c4 05       # line 0 taken
Q 00000084 06       # line 1 held off in handler
Q 00000084 04
Q 00000084 00
S 00000100 80000001
S 00000104 00000001
S 00000108 fffffffc
S 0000010c 12345680
S 00000110 00001234
S 00000200 00000030 # overflow
S 00000204 00000054
S 00000114 00001234
S 00000208 00000028 # reserved
S 0000020c 0000005c
S 00000210 00000020 # syscall
S 00000214 00000060
S 00000118 00001001
S 00000218 00000000 # interrupt
S 0000021c 000000c4
S 00000220 00000000 # held-off interrupt
S 00000224 000000c4
S 0000011c 00000055
S 00000228 00000000 # unmasked by mtc0
S 0000022c 000000cc
S 00000120 00000077
F 00000080
F 00000058
F 00000080
F 00000060
F 00000080
F 00000064
F 00000080
F 000000c4
F 00000080
F 000000c4
F 00000080
F 000000cc

// File: tests/pcpu_tb.sv
`timescale 1ns/10ps

module pcpu_tb;
	import pcpu_pkg::*;

	localparam int SEED          = 99558;
	localparam int MEM_WORDS     = 256;  // Both memories, word indexed by addr[9:2]
	localparam int FETCH_TIMEOUT = 300;  // Cycles per expected fetch
	localparam int STORE_TIMEOUT = 100;  // Cycles for the last stores to drain

	logic       clk;
	logic       arst_n;
	logic [5:0] irq;
	word_t      inst_addr;
	word_t      inst_data;
	word_t      mem_addr;
	word_t      mem_data;
	word_t      mem_data_in;
	logic       mem_we;

	word_t      imem [MEM_WORDS];
	word_t      dmem [MEM_WORDS];
	word_t      st_addr_q [$];   // Expected stores, in bus order
	word_t      st_data_q [$];
	word_t      fetch_q [$];     // Vector and return points
	word_t      irq_addr_q [$];  // Interrupt events, fired in order
	logic [5:0] irq_val_q [$];
	int         store_errors = 0;
	int         timeouts = 0;
	int         setup_errors = 0;

	pcpu #(
		.RESET_PC   (32'h0000_0000),
		.EXC_VECTOR (32'h0000_0080)
	) dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.inst_data   (inst_data),
		.mem_data_in (mem_data_in),
		.irq         (irq),
		.inst_addr   (inst_addr),
		.mem_addr    (mem_addr),
		.mem_data    (mem_data),
		.mem_we      (mem_we)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	////////////////////
	// Memory models
	////////////////////

	assign inst_data   = imem[inst_addr[9:2]]; // Same-cycle answers
	assign mem_data_in = dmem[mem_addr[9:2]];

	always @(posedge clk) begin
		if (mem_we) dmem[mem_addr[9:2]] <= mem_data;
	end

	// Next event fires the first time its address is on the fetch bus
	always @(posedge clk) begin
		if (arst_n && irq_addr_q.size() > 0 && inst_addr == irq_addr_q[0]) begin
			irq <= irq_val_q[0];
			void'(irq_addr_q.pop_front());
			void'(irq_val_q.pop_front());
		end
	end

	always @(negedge clk) begin
		if (arst_n && mem_we) check_store(mem_addr, mem_data); // Mid-cycle, outputs settled
	end

	////////////////////
	// Checks
	////////////////////

	task automatic check_store(input word_t addr, input word_t data);
		word_t exp_addr;
		word_t exp_data;
		if (st_addr_q.size() == 0) begin
			$display("ERR @%0t: extra store of %h to %h", $time, data, addr);
			store_errors++;
		end else begin
			exp_addr = st_addr_q.pop_front();
			exp_data = st_data_q.pop_front();
			if (addr !== exp_addr || data !== exp_data) begin
				$display("ERR @%0t: store %h to %h, expected %h to %h",
					$time, data, addr, exp_data, exp_addr);
				store_errors++;
			end
		end
	endtask

	task automatic check_fetch(input word_t addr);
		int   cycles;
		logic found;
		cycles = 0;
		found  = 1'b0;
		while (!found && cycles < FETCH_TIMEOUT) begin
			@(negedge clk);
			found = (inst_addr == addr);
			cycles++;
		end
		if (!found) begin
			$display("Timeout: address %h was never fetched within %0d cycles",
				addr, FETCH_TIMEOUT);
			timeouts++;
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int         fd;
		int         n;
		int         cycles;
		string      line;
		logic [7:0] kind;
		word_t      a;
		word_t      d;
		irq    = '0;
		arst_n = 1'b0;
		void'($urandom(SEED));
		for (int i = 0; i < MEM_WORDS; i++) begin
			imem[i] = {16'h3400, 16'(i * 4)}; // ori $0 with the address, harmless
			dmem[i] = $urandom;
		end

		fd = $fopen("tests/pcpu_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open tests/pcpu_cases.txt");
			setup_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 0 && line[0] != "#" && line[0] != "\n") begin
					d = '0;
					n = $sscanf(line, "%c %h %h", kind, a, d);
					case (kind)
						"P": imem[a[9:2]] = d;
						"D": dmem[a[9:2]] = d;
						"Q": begin
							irq_addr_q.push_back(a);
							irq_val_q.push_back(d[5:0]);
						end
						"S": begin
							st_addr_q.push_back(a);
							st_data_q.push_back(d);
						end
						"F": fetch_q.push_back(a);
						default: begin
							$display("Unknown line in cases file: %s", line);
							setup_errors++;
						end
					endcase
				end
			end
			$fclose(fd);
		end

		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// Vectors and return points, in order
		while (fetch_q.size() > 0 && timeouts == 0) begin
			a = fetch_q.pop_front();
			check_fetch(a);
		end

		cycles = 0;
		while (timeouts == 0 && st_addr_q.size() > 0 && cycles < STORE_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (timeouts == 0 && st_addr_q.size() > 0) begin
			$display("Timeout: %0d expected stores never appeared on the bus", st_addr_q.size());
			timeouts++;
		end

		$display("Errors: store %0d, timeout %0d, setup %0d", store_errors, timeouts, setup_errors);
		if (store_errors == 0 && timeouts == 0 && setup_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
